// File: flist.f
logic/rv_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv_core_top.sv
sim/rv_core_assertions.sv
sim/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/reg_file.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/hazard_unit.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/rv_core_top.sv
  - target: simulation
    files:
      - sim/rv_core_assertions.sv
      - sim/rv_core_tb.sv

// File: sim/rv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

    localparam logic [31:0] RESET_PC     = 32'h0000_0100;
    localparam int          RESET_CYCLES = 10;
    localparam int          MAX_INSTR    = 40;
    localparam int          WORST_CPI    = 4;  // load-use, squash and memory wait
    localparam int          TIMEOUT      = MAX_INSTR * WORST_CPI + MAX_INSTR;
    localparam int          DRAIN_CYCLES = 20; // room for a stray store to show up

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic              clk = 1'b0;
    logic              rst;
    logic [31:0]       imem_addr;
    logic [31:0]       imem_data;
    rv_pkg::dmem_req_t dmem_req;
    logic              dmem_ready = 1'b0;
    logic [31:0]       dmem_rdata;

    logic [31:0] rom [64];
    logic [31:0] mem [64];
    logic [31:0] rom_offset;
    logic [31:0] rand_state = 32'd58;
    store_t      expected [$];
    store_t      head;
    int          cycles;

    always #5 clk = ~clk;

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) i_rv_core_top (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_ready (dmem_ready),
        .dmem_rdata (dmem_rdata)
    );

    // ==========================================================
    // instruction encoders
    // ==========================================================
    function automatic logic [31:0] r_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [4:0] rd);
        return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // offset bit 0 is dropped, as in the B format
    function automatic logic [31:0] branch_word(input logic [12:0] offset, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] funct3);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] next_rand(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic load_program();
        for (int k = 0; k < 64; k++) begin
            rom[k] = 32'h0000_0013; // nop
        end
        rom[0]  = i_word(12'h123, 5'd0, 3'b000, 5'd1, OPC_OP_IMM); // addi x1, x0, 0x123
        rom[1]  = i_word(12'h045, 5'd1, 3'b000, 5'd2, OPC_OP_IMM); // addi x2, x1, 0x45
        rom[2]  = r_word(7'h00, 5'd1, 5'd2, 5'd3);                 // add x3, x2, x1
        rom[3]  = r_word(7'h20, 5'd3, 5'd1, 5'd4);                 // sub x4, x1, x3
        rom[4]  = store_word(12'd0, 5'd4, 5'd0);                   // sw x4, 0(x0)
        rom[5]  = store_word(12'd4, 5'd3, 5'd0);                   // sw x3, 4(x0)
        rom[6]  = i_word(12'd20, 5'd0, 3'b010, 5'd5, OPC_LOAD);    // lw x5, 20(x0)
        rom[7]  = r_word(7'h00, 5'd2, 5'd5, 5'd6);                 // add x6, x5, x2
        rom[8]  = store_word(12'd8, 5'd6, 5'd0);                   // sw x6, 8(x0)
        rom[9]  = branch_word(13'd12, 5'd1, 5'd1, 3'b000);         // beq x1, x1, +12
        rom[10] = store_word(12'd12, 5'd1, 5'd0);                  // jumped over
        rom[11] = store_word(12'd16, 5'd2, 5'd0);                  // jumped over
        rom[12] = branch_word(13'd8, 5'd1, 5'd1, 3'b001);          // bne x1, x1, +8
        rom[13] = store_word(12'd24, 5'd2, 5'd0);                  // sw x2, 24(x0)
        rom[14] = i_word(12'd77, 5'd0, 3'b000, 5'd0, OPC_OP_IMM);  // addi x0, x0, 77
        rom[15] = store_word(12'd28, 5'd0, 5'd0);                  // sw x0, 28(x0)
        rom[16] = r_word(7'h00, 5'd1, 5'd0, 5'd7);                 // add x7, x0, x1
        rom[17] = store_word(12'd32, 5'd7, 5'd0);                  // sw x7, 32(x0)
        rom[18] = branch_word(13'd0, 5'd0, 5'd0, 3'b000);          // beq x0, x0, 0
    endtask

    // ==========================================================
    // memory models
    // ==========================================================
    assign rom_offset = imem_addr - RESET_PC;
    assign imem_data  = rom[rom_offset[7:2]];
    assign dmem_rdata = mem[dmem_req.addr[7:2]];

    // ready about 60% of the cycles
    always @(posedge clk) begin
        rand_state = next_rand(rand_state);
        dmem_ready <= (rand_state[23:16] < 8'd154);
    end

    // a transfer seen here completes at the next rising edge
    always @(negedge clk) begin
        if (!rst && dmem_req.valid && dmem_ready && dmem_req.write) begin
            assert (expected.size() > 0) else begin
                $display("Unexpected store of %h to address %h at %0t after all expected stores",
                         dmem_req.wdata, dmem_req.addr, $time);
                $display("Simulation failed");
                $fatal(1, "store after the expected sequence");
            end
            head = expected.pop_front();
            assert ((dmem_req.addr == head.addr) && (dmem_req.wdata == head.data)) else begin
                $display("Fail %0t: store addr %h data %h, expected addr %h data %h",
                         $time, dmem_req.addr, dmem_req.wdata, head.addr, head.data);
                $display("Simulation failed");
                $fatal(1, "store mismatch");
            end
            mem[dmem_req.addr[7:2]] = dmem_req.wdata;
        end
    end

    always @(negedge clk) begin
        if (i_rv_core_top.i_rv_core_assertions.failures != 0) begin
            $display("A handshake or reset assertion failed by %0t", $time);
            $display("Simulation failed");
            $fatal(1, "concurrent assertion failure");
        end
    end

    // ==========================================================
    // main sequence
    // ==========================================================
    initial begin
        rst = 1'b1;
        load_program();
        for (int k = 0; k < 64; k++) begin
            mem[k] = 32'h5A00_0000 + 32'(k) * 32'h0001_0003;
        end
        expected.push_back('{addr: 32'd0,  data: 32'hFFFF_FE98}); // 0x123 - 0x28b
        expected.push_back('{addr: 32'd4,  data: 32'h0000_028B}); // 0x168 + 0x123
        expected.push_back('{addr: 32'd8,  data: 32'h5A05_0177}); // word 5 plus 0x168
        expected.push_back('{addr: 32'd24, data: 32'h0000_0168});
        expected.push_back('{addr: 32'd28, data: 32'h0000_0000});
        expected.push_back('{addr: 32'd32, data: 32'h0000_0123});
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while ((expected.size() != 0) && (cycles < TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        if (expected.size() == 0) begin
            repeat (DRAIN_CYCLES) @(posedge clk);
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Timeout after %0d cycles, %0d expected stores did not appear",
                     cycles, expected.size());
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

// File: sim/rv_core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_assertions #(
    parameter logic [31:0] RESET_PC = '0
) (
    input logic              clk,
    input logic              rst,
    input logic [31:0]       imem_addr,
    input rv_pkg::dmem_req_t dmem_req,
    input logic              dmem_ready
);

    int unsigned failures = 0; // polled by the testbench

    // ==========================================================
    // reset behavior
    // ==========================================================
    reset_quiet: assert property (@(posedge clk)
        rst |-> (!dmem_req.valid && (imem_addr == RESET_PC)))
    else begin
        $error("data request made or fetch address off the reset vector during reset");
        failures++;
    end

    // ==========================================================
    // data memory handshake
    // ==========================================================
    req_stable: assert property (@(posedge clk) disable iff (rst)
        (dmem_req.valid && !dmem_ready) |=> $stable(dmem_req))
    else begin
        $error("data request changed or was withdrawn while waiting for ready");
        failures++;
    end

    req_known: assert property (@(posedge clk) disable iff (rst)
        dmem_req.valid |-> !$isunknown(dmem_req))
    else begin
        $error("data request carries unknown bits");
        failures++;
    end

    fetch_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
    else begin
        $error("fetch address not word aligned");
        failures++;
    end

endmodule

bind rv_core_top rv_core_assertions #(
    .RESET_PC (RESET_PC)
) i_rv_core_assertions (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .dmem_req   (dmem_req),
    .dmem_ready (dmem_ready)
);

`default_nettype wire

// File: logic/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    input  logic [rv_pkg::XLEN-1:0] imem_data,
    output rv_pkg::dmem_req_t       dmem_req,
    input  logic                    dmem_ready,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata
);

    rv_pkg::if_id_t    if_id;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::ex_mem_t   ex_mem;
    rv_pkg::mem_wb_t   mem_wb;
    rv_pkg::redirect_t redirect;
    rv_pkg::wb_t       wb;
    rv_pkg::fwd_sel_e  fwd_a;
    rv_pkg::fwd_sel_e  fwd_b;
    logic              hold;
    logic              bubble;
    logic              squash;
    logic              mem_stall;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch_stage (
        .clk       (clk),
        .rst       (rst),
        .hold      (hold),
        .squash    (squash),
        .mem_stall (mem_stall),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .if_id     (if_id)
    );

    decode_stage i_decode_stage (
        .clk       (clk),
        .rst       (rst),
        .if_id     (if_id),
        .wb        (wb),
        .bubble    (bubble),
        .squash    (squash),
        .mem_stall (mem_stall),
        .id_ex     (id_ex)
    );

    hazard_unit i_hazard_unit (
        .if_id          (if_id),
        .id_ex          (id_ex),
        .ex_mem         (ex_mem),
        .mem_wb         (mem_wb),
        .redirect       (redirect),
        .dmem_req_valid (dmem_req.valid),
        .dmem_ready     (dmem_ready),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .hold           (hold),
        .bubble         (bubble),
        .squash         (squash),
        .mem_stall      (mem_stall)
    );

    execute_stage i_execute_stage (
        .clk          (clk),
        .rst          (rst),
        .id_ex        (id_ex),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .fwd_mem_data (ex_mem.alu_result),
        .fwd_wb_data  (wb.data),
        .mem_stall    (mem_stall),
        .redirect     (redirect),
        .ex_mem       (ex_mem)
    );

    memory_stage i_memory_stage (
        .clk        (clk),
        .rst        (rst),
        .ex_mem     (ex_mem),
        .dmem_req   (dmem_req),
        .dmem_ready (dmem_ready),
        .dmem_rdata (dmem_rdata),
        .mem_wb_q   (mem_wb),
        .wb         (wb)
    );

endmodule

`default_nettype wire

// File: logic/memory_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::ex_mem_t         ex_mem,
    output rv_pkg::dmem_req_t       dmem_req,
    input  logic                    dmem_ready,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata,
    output rv_pkg::mem_wb_t         mem_wb_q,
    output rv_pkg::wb_t             wb
);

    logic stall; // request still waiting for ready

    // request comes straight from EX/MEM, which holds while waiting
    always_comb begin
        dmem_req.valid = ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write;
        dmem_req.write = ex_mem.ctrl.mem_write;
        dmem_req.addr  = ex_mem.alu_result;
        dmem_req.wdata = ex_mem.store_data;
    end

    assign stall = dmem_req.valid && !dmem_ready;

    // MEM/WB register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb_q <= '0;
        end else if (!stall) begin
            mem_wb_q.alu_result <= ex_mem.alu_result;
            if (ex_mem.ctrl.mem_read) begin
                mem_wb_q.load_data <= dmem_rdata; // accepting edge
            end
            mem_wb_q.rd   <= ex_mem.rd;
            mem_wb_q.ctrl <= ex_mem.ctrl;
        end
    end

    // ==========================================================
    // writeback
    // ==========================================================
    always_comb begin
        wb.we   = mem_wb_q.ctrl.reg_write && !stall; // quiet while frozen
        wb.rd   = mem_wb_q.rd;
        wb.data = mem_wb_q.ctrl.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;
    end

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::id_ex_t          id_ex,
    input  rv_pkg::fwd_sel_e        fwd_a,
    input  rv_pkg::fwd_sel_e        fwd_b,
    input  logic [rv_pkg::XLEN-1:0] fwd_mem_data,
    input  logic [rv_pkg::XLEN-1:0] fwd_wb_data,
    input  logic                    mem_stall,
    output rv_pkg::redirect_t       redirect,
    output rv_pkg::ex_mem_t         ex_mem
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;  // forwarded rs2, also store data
    logic [rv_pkg::XLEN-1:0] alu_b;
    logic [rv_pkg::XLEN-1:0] alu_result;

    function automatic logic [rv_pkg::XLEN-1:0] operand(
        input rv_pkg::fwd_sel_e        sel,
        input logic [rv_pkg::XLEN-1:0] reg_val
    );
        case (sel)
            rv_pkg::fwd_from_mem: return fwd_mem_data;
            rv_pkg::fwd_from_wb:  return fwd_wb_data;
            default:              return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a = operand(fwd_a, id_ex.rs1_data);
        op_b = operand(fwd_b, id_ex.rs2_data);
    end

    assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            rv_pkg::alu_sub: alu_result = op_a - alu_b;
            default:         alu_result = op_a + alu_b;
        endcase
    end

    // ==========================================================
    // branch resolution
    // ==========================================================
    always_comb begin
        redirect.taken  = id_ex.ctrl.is_branch && ((op_a == op_b) != id_ex.ctrl.branch_ne);
        redirect.target = id_ex.pc + id_ex.imm;
    end

    // EX/MEM register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem <= '0;
        end else if (!mem_stall) begin
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= op_b;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.ctrl       <= id_ex.ctrl;
        end
    end

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  rv_pkg::if_id_t    if_id,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::mem_wb_t   mem_wb,
    input  rv_pkg::redirect_t redirect,
    input  logic              dmem_req_valid,
    input  logic              dmem_ready,
    output rv_pkg::fwd_sel_e  fwd_a,
    output rv_pkg::fwd_sel_e  fwd_b,
    output logic              hold,
    output logic              bubble,
    output logic              squash,
    output logic              mem_stall
);

    logic load_use;

    // youngest writer wins, x0 never forwarded
    function automatic rv_pkg::fwd_sel_e pick_source(
        input logic [rv_pkg::REG_ADDR_W-1:0] rs
    );
        if (ex_mem.ctrl.reg_write && (ex_mem.rd != '0) && (ex_mem.rd == rs)) begin
            return rv_pkg::fwd_from_mem;
        end else if (mem_wb.ctrl.reg_write && (mem_wb.rd != '0) && (mem_wb.rd == rs)) begin
            return rv_pkg::fwd_from_wb;
        end
        return rv_pkg::fwd_none;
    endfunction

    always_comb begin
        fwd_a = pick_source(id_ex.rs1);
        fwd_b = pick_source(id_ex.rs2);
    end

    // load in EX feeding the instruction in ID
    assign load_use = id_ex.ctrl.mem_read && (id_ex.rd != '0)
                   && ((id_ex.rd == if_id.instr.r.rs1) || (id_ex.rd == if_id.instr.r.rs2));

    assign hold      = load_use; // PC and IF/ID wait one cycle
    assign bubble    = load_use;
    assign squash    = redirect.taken;
    assign mem_stall = dmem_req_valid && !dmem_ready;

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic           clk,
    input  logic           rst,
    input  rv_pkg::if_id_t if_id,
    input  rv_pkg::wb_t    wb,
    input  logic           bubble,
    input  logic           squash,
    input  logic           mem_stall,
    output rv_pkg::id_ex_t id_ex
);

    rv_pkg::instr_u          instr;
    rv_pkg::ctrl_t           ctrl;
    logic [rv_pkg::XLEN-1:0] imm;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;

    assign instr = if_id.instr;

    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (instr.r.rs1),
        .rs2      (instr.r.rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // ==========================================================
    // control decode
    // ==========================================================
    always_comb begin
        ctrl = '0; // unknown opcodes behave as nop
        case (instr.r.opcode)
            rv_pkg::OPC_OP: begin
                ctrl.reg_write = 1'b1;
                if (instr.r.funct7[5]) begin
                    ctrl.alu_op = rv_pkg::alu_sub;
                end
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1; // address = rs1 + imm
            end
            rv_pkg::OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                // only beq (000) and bne (001)
                ctrl.is_branch = (instr.b.funct3[2:1] == 2'b00);
                ctrl.branch_ne = instr.b.funct3[0];
            end
            default: ;
        endcase
    end

    // immediate from the matching format view
    always_comb begin
        case (instr.r.opcode)
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD:
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            rv_pkg::OPC_STORE:
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            rv_pkg::OPC_BRANCH:
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            default:
                imm = '0; // r-type has none
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex <= '0;
        end else if (!mem_stall) begin
            id_ex.pc       <= if_id.pc;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
            id_ex.rs1      <= instr.r.rs1;
            id_ex.rs2      <= instr.r.rs2;
            id_ex.rd       <= instr.r.rd;
            if (bubble || squash) begin
                id_ex.ctrl <= '0;
            end else begin
                id_ex.ctrl <= ctrl;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    hold,
    input  logic                    squash,
    input  logic                    mem_stall,
    input  rv_pkg::redirect_t       redirect,
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    input  logic [rv_pkg::XLEN-1:0] imem_data,
    output rv_pkg::if_id_t          if_id
);

    logic [rv_pkg::XLEN-1:0] pc;
    logic [rv_pkg::XLEN-1:0] pc_next;

    assign imem_addr = pc; // imem answers in the same cycle
    assign pc_next   = redirect.taken ? redirect.target : pc + rv_pkg::XLEN'(4);

    // a taken branch overrides a load-use hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!mem_stall && (redirect.taken || !hold)) begin
            pc <= pc_next;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_id.pc    <= RESET_PC;
            if_id.instr <= rv_pkg::NOP_INSTR;
        end else if (!mem_stall) begin
            if (squash) begin
                if_id.instr <= rv_pkg::NOP_INSTR; // wrong-path fetch dropped
            end else if (!hold) begin
                if_id.pc    <= pc;
                if_id.instr <= imem_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
    input  rv_pkg::wb_t                   wb,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data
);

    logic [rv_pkg::XLEN-1:0] regs [32];
    logic                    wr_live;

    assign wr_live = wb.we && (wb.rd != '0); // x0 is never written

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_live) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write is visible to decode
    assign rs1_data = (wr_live && (wb.rd == rs1)) ? wb.data : regs[rs1];
    assign rs2_data = (wr_live && (wb.rd == rs2)) ? wb.data : regs[rs2];

endmodule

`default_nettype wire

// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ==========================================================
    // widths and fixed encodings
    // ==========================================================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    localparam logic [6:0] OPC_OP     = 7'b0110011; // add, sub
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // addi
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // lw
    localparam logic [6:0] OPC_STORE  = 7'b0100011; // sw
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // beq, bne

    typedef enum logic {
        alu_add = 1'b0,
        alu_sub = 1'b1
    } alu_op_e;

    // operand source for EX
    typedef enum logic [1:0] {
        fwd_none     = 2'b00,
        fwd_from_mem = 2'b01, // EX/MEM alu result
        fwd_from_wb  = 2'b10  // writeback mux output
    } fwd_sel_e;

    // ==========================================================
    // instruction word views
    // ==========================================================
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    // branch offset bits are scattered, bit 0 implied zero
    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

    // ==========================================================
    // control and stage registers
    // ==========================================================
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;   // 1 selects immediate
        logic    is_branch;
        logic    branch_ne; // bne when set, beq otherwise
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        ctrl_t                 ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       load_data;
        logic [REG_ADDR_W-1:0] rd;
        ctrl_t                 ctrl;
    } mem_wb_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic            write;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

`default_nettype wire
